/* hw/tdu_pkg.sv */
//------------------------------------------------------------
// Trigger unit widths, CSR offsets, request and monitor types
// tdata1 field views and per-trigger state types
//------------------------------------------------------------
`default_nettype none

package tdu_pkg;

    // Data and address width
    localparam int unsigned XLEN       = 32;
    localparam int unsigned CSR_OFFS_W = 3;
    localparam int unsigned ICOUNT_W   = 14;

    // CSR offsets inside the trigger block
    localparam logic [CSR_OFFS_W-1:0] OFFS_TSELECT = 3'd0;
    localparam logic [CSR_OFFS_W-1:0] OFFS_TDATA1  = 3'd1;
    localparam logic [CSR_OFFS_W-1:0] OFFS_TDATA2  = 3'd2;
    localparam logic [CSR_OFFS_W-1:0] OFFS_TINFO   = 3'd4;

    // tdata1 type codes, also the tinfo bit positions
    localparam logic [3:0] TYPE_MCONTROL = 4'd2;
    localparam logic [3:0] TYPE_ICOUNT   = 4'd3;

    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_SET   = 2'd2,
        CMD_CLEAR = 2'd3
    } csr_cmd_e;

    typedef struct packed {
        logic                  req;
        csr_cmd_e              cmd;
        logic [CSR_OFFS_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
    } csr_req_s;

    // Instruction in execute, req marks retirement
    typedef struct packed {
        logic            vd;
        logic            req;
        logic [XLEN-1:0] addr;
    } imon_s;

    // Load or store access from the LSU
    typedef struct packed {
        logic            vd;
        logic            load;
        logic            store;
        logic [XLEN-1:0] addr;
    } dmon_s;

    //--------------------------------------------------------
    // tdata1 views
    //--------------------------------------------------------

    // Address match trigger
    typedef struct packed {
        logic [3:0] tr_type;
        logic       dmode;
        logic [5:0] maskmax;
        logic       hit;
        logic       select;
        logic       timing;
        logic [5:0] action;
        logic       chain;
        logic [3:0] match;
        logic       m;
        logic       rsvd;
        logic       s;
        logic       u;
        logic       execute;
        logic       store;
        logic       load;
    } mcontrol_s;

    // Instruction count trigger
    typedef struct packed {
        logic [3:0]          tr_type;
        logic                dmode;
        logic [1:0]          rsvd_hi;
        logic                hit;
        logic [ICOUNT_W-1:0] count;
        logic                m;
        logic [2:0]          rsvd_lo;
        logic [5:0]          action;
    } icount_s;

    // Same word, decoded by the kind of the selected trigger
    typedef union packed {
        mcontrol_s       mc;
        icount_s         ic;
        logic [XLEN-1:0] raw;
    } tdata1_u;

    //--------------------------------------------------------
    // Stored trigger state
    //--------------------------------------------------------

    typedef struct packed {
        logic m;
        logic execute;
        logic load;
        logic store;
        logic action;
        logic hit;
    } mc_state_s;

    typedef struct packed {
        logic                m;
        logic                action;
        logic                hit;
        logic [ICOUNT_W-1:0] count;
        logic                skip;
    } ic_state_s;

endpackage

`default_nettype wire

/* hw/tdu_csr_port.sv */
//------------------------------------------------------------
// CSR access port: tselect, write strobes, read multiplexer
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tdu_csr_port import tdu_pkg::*; #(
    parameter int unsigned MTRIG_NUM = 2
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire csr_req_s                       csr_req_i,
    input  wire mc_state_s [MTRIG_NUM-1:0]      mc_state_i,
    input  wire logic [MTRIG_NUM-1:0][XLEN-1:0] tdata2_i,
    input  wire ic_state_s                      ic_state_i,
    output logic [XLEN-1:0]                     csr_rdata_o,
    output tdata1_u                             wr_data_o,
    output logic [MTRIG_NUM-1:0]                mc_we_o,
    output logic [MTRIG_NUM-1:0]                td2_we_o,
    output logic                                ic_we_o
);

    localparam int unsigned ALLTRIG_NUM = MTRIG_NUM + 1;
    localparam int unsigned TSEL_W      = $clog2(ALLTRIG_NUM);

    logic [TSEL_W-1:0] tsel_q;
    logic              sel_ic;
    logic              wr_req;
    tdata1_u           rd_word;
    tdata1_u           wr_data;

    // Icount trigger sits above the address triggers
    assign sel_ic = (tsel_q == TSEL_W'(MTRIG_NUM));

    //--------------------------------------------------------
    // Read multiplexer
    //--------------------------------------------------------
    always_comb begin
        rd_word = '0;
        if (csr_req_i.req) begin
            case (csr_req_i.addr)
                OFFS_TSELECT: begin
                    rd_word.raw = XLEN'(tsel_q);
                end
                OFFS_TDATA1: begin
                    if (sel_ic) begin
                        rd_word.ic.tr_type = TYPE_ICOUNT;
                        rd_word.ic.hit     = ic_state_i.hit;
                        rd_word.ic.count   = ic_state_i.count;
                        rd_word.ic.m       = ic_state_i.m;
                        rd_word.ic.action  = {5'b0, ic_state_i.action};
                    end
                    for (int i = 0; i < MTRIG_NUM; i++) begin
                        if (tsel_q == TSEL_W'(i)) begin
                            rd_word.mc.tr_type = TYPE_MCONTROL;
                            rd_word.mc.hit     = mc_state_i[i].hit;
                            rd_word.mc.action  = {5'b0, mc_state_i[i].action};
                            rd_word.mc.m       = mc_state_i[i].m;
                            rd_word.mc.execute = mc_state_i[i].execute;
                            rd_word.mc.store   = mc_state_i[i].store;
                            rd_word.mc.load    = mc_state_i[i].load;
                        end
                    end
                end
                OFFS_TDATA2: begin
                    // No tdata2 behind icount, reads zero
                    for (int i = 0; i < MTRIG_NUM; i++) begin
                        if (tsel_q == TSEL_W'(i)) begin
                            rd_word.raw = tdata2_i[i];
                        end
                    end
                end
                OFFS_TINFO: begin
                    rd_word.raw[sel_ic ? TYPE_ICOUNT : TYPE_MCONTROL] = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    //--------------------------------------------------------
    // Write data merge
    //--------------------------------------------------------
    always_comb begin
        wr_req  = 1'b0;
        wr_data = '0;
        case (csr_req_i.cmd)
            CMD_WRITE: begin
                wr_req      = 1'b1;
                wr_data.raw = csr_req_i.wdata;
            end
            CMD_SET: begin
                wr_req      = |csr_req_i.wdata;
                wr_data.raw = rd_word.raw | csr_req_i.wdata;
            end
            CMD_CLEAR: begin
                wr_req      = |csr_req_i.wdata;
                wr_data.raw = rd_word.raw & ~csr_req_i.wdata;
            end
            default: begin
            end
        endcase
        wr_req = wr_req & csr_req_i.req;
    end

    // One-hot strobes from offset and tselect
    always_comb begin
        for (int i = 0; i < MTRIG_NUM; i++) begin
            mc_we_o[i]  = wr_req & (csr_req_i.addr == OFFS_TDATA1) & (tsel_q == TSEL_W'(i));
            td2_we_o[i] = wr_req & (csr_req_i.addr == OFFS_TDATA2) & (tsel_q == TSEL_W'(i));
        end
    end

    assign ic_we_o = wr_req & (csr_req_i.addr == OFFS_TDATA1) & sel_ic;

    // tselect keeps its value on an out-of-range write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tsel_q <= '0;
        end else if (wr_req && csr_req_i.addr == OFFS_TSELECT &&
                     wr_data.raw < XLEN'(ALLTRIG_NUM)) begin
            tsel_q <= wr_data.raw[TSEL_W-1:0];
        end
    end

    assign csr_rdata_o = rd_word.raw;
    assign wr_data_o   = wr_data;

endmodule

`default_nettype wire

/* hw/tdu_mcontrol_bank.sv */
//------------------------------------------------------------
// Address trigger bank: mcontrol fields and tdata2 words
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tdu_mcontrol_bank import tdu_pkg::*; #(
    parameter int unsigned MTRIG_NUM = 2
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire tdata1_u                   wr_data_i,
    input  wire logic [MTRIG_NUM-1:0]      mc_we_i,
    input  wire logic [MTRIG_NUM-1:0]      td2_we_i,
    input  wire logic [MTRIG_NUM-1:0]      bp_retire_i,
    output mc_state_s [MTRIG_NUM-1:0]      mc_state_o,
    output logic [MTRIG_NUM-1:0][XLEN-1:0] tdata2_o
);

    mc_state_s [MTRIG_NUM-1:0]      mc_q;
    logic [MTRIG_NUM-1:0][XLEN-1:0] td2_q;

    //--------------------------------------------------------
    // mcontrol fields
    //--------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mc_q <= '0;
        end else begin
            for (int i = 0; i < MTRIG_NUM; i++) begin
                if (mc_we_i[i]) begin
                    mc_q[i].m       <= wr_data_i.mc.m;
                    mc_q[i].execute <= wr_data_i.mc.execute;
                    mc_q[i].load    <= wr_data_i.mc.load;
                    mc_q[i].store   <= wr_data_i.mc.store;
                    // Only action code 1 enters debug mode
                    mc_q[i].action  <= (wr_data_i.mc.action == 6'd1);
                    mc_q[i].hit     <= wr_data_i.mc.hit;
                end else if (bp_retire_i[i]) begin
                    // Sticky until software clears it
                    mc_q[i].hit <= 1'b1;
                end
            end
        end
    end

    //--------------------------------------------------------
    // tdata2 match addresses
    //--------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            td2_q <= '0;
        end else begin
            for (int i = 0; i < MTRIG_NUM; i++) begin
                if (td2_we_i[i]) begin
                    td2_q[i] <= wr_data_i.raw;
                end
            end
        end
    end

    assign mc_state_o = mc_q;
    assign tdata2_o   = td2_q;

endmodule

`default_nettype wire

/* hw/tdu_icount.sv */
//------------------------------------------------------------
// Instruction count trigger with one-instruction skip
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tdu_icount import tdu_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    tdu_dsbl_i,
    input  wire tdata1_u wr_data_i,
    input  wire logic    ic_we_i,
    input  wire imon_s   imon_i,
    input  wire logic    retire_i,
    output ic_state_s    ic_state_o,
    output logic         ic_hit_o
);

    ic_state_s ic_q;
    logic      armed;
    logic      step;

    assign armed = ~tdu_dsbl_i & ic_q.m;

    // Retiring instruction while counting
    assign step = armed & imon_i.vd & imon_i.req & (ic_q.count != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ic_q <= '0;
        end else if (ic_we_i) begin
            ic_q.m      <= wr_data_i.ic.m;
            ic_q.action <= (wr_data_i.ic.action == 6'd1);
            ic_q.hit    <= wr_data_i.ic.hit;
            ic_q.count  <= wr_data_i.ic.count;
            // Skip the instruction that wrote the CSR
            ic_q.skip   <= wr_data_i.ic.m;
        end else begin
            if (retire_i) begin
                ic_q.hit <= 1'b1;
            end
            if (step) begin
                if (ic_q.skip) begin
                    ic_q.skip <= 1'b0;
                end else begin
                    ic_q.count <= ic_q.count - 1'b1;
                end
            end
        end
    end

    // Fires on the last counted instruction
    assign ic_hit_o   = armed & imon_i.vd & (ic_q.count == ICOUNT_W'(1)) & ~ic_q.skip;
    assign ic_state_o = ic_q;

endmodule

`default_nettype wire

/* hw/tdu_match.sv */
//------------------------------------------------------------
// Address comparators, breakpoint requests, debug entry
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tdu_match import tdu_pkg::*; #(
    parameter  int unsigned MTRIG_NUM   = 2,
    localparam int unsigned ALLTRIG_NUM = MTRIG_NUM + 1
) (
    input  wire logic                           tdu_dsbl_i,
    input  wire mc_state_s [MTRIG_NUM-1:0]      mc_state_i,
    input  wire logic [MTRIG_NUM-1:0][XLEN-1:0] tdata2_i,
    input  wire ic_state_s                      ic_state_i,
    input  wire logic                           ic_hit_i,
    input  wire imon_s                          imon_i,
    input  wire dmon_s                          dmon_i,
    input  wire logic [ALLTRIG_NUM-1:0]         bp_retire_i,
    output logic [ALLTRIG_NUM-1:0]              ibrkpt_match_o,
    output logic                                ibrkpt_exc_req_o,
    output logic [MTRIG_NUM-1:0]                dbrkpt_match_o,
    output logic                                dbrkpt_exc_req_o,
    output logic                                dmode_req_o
);

    logic [MTRIG_NUM-1:0] exec_hit;
    logic [MTRIG_NUM-1:0] ldst_hit;

    //--------------------------------------------------------
    // Per-trigger comparators
    //--------------------------------------------------------
    always_comb begin
        for (int i = 0; i < MTRIG_NUM; i++) begin
            // Breakpoint on fetch address
            exec_hit[i] = ~tdu_dsbl_i
                        & mc_state_i[i].m
                        & mc_state_i[i].execute
                        & imon_i.vd
                        & (imon_i.addr == tdata2_i[i]);
            // Watchpoint on load or store address
            ldst_hit[i] = ~tdu_dsbl_i
                        & mc_state_i[i].m
                        & dmon_i.vd
                        & ((mc_state_i[i].load & dmon_i.load)
                         | (mc_state_i[i].store & dmon_i.store))
                        & (dmon_i.addr == tdata2_i[i]);
        end
    end

    // Icount in the top bit
    assign ibrkpt_match_o   = {ic_hit_i, exec_hit};
    assign ibrkpt_exc_req_o = (|exec_hit) | ic_hit_i;
    assign dbrkpt_match_o   = ldst_hit;
    assign dbrkpt_exc_req_o = |ldst_hit;

    //--------------------------------------------------------
    // Debug mode entry on retirement
    //--------------------------------------------------------
    always_comb begin
        dmode_req_o = ic_state_i.action & bp_retire_i[MTRIG_NUM];
        for (int i = 0; i < MTRIG_NUM; i++) begin
            dmode_req_o = dmode_req_o | (mc_state_i[i].action & bp_retire_i[i]);
        end
    end

endmodule

`default_nettype wire

/* hw/tdu_top.sv */
//------------------------------------------------------------
// Trigger debug unit top level
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tdu_top import tdu_pkg::*; #(
    parameter  int unsigned MTRIG_NUM   = 2,
    localparam int unsigned ALLTRIG_NUM = MTRIG_NUM + 1
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   tdu_dsbl_i,
    input  wire csr_req_s               csr_req_i,
    input  wire imon_s                  imon_i,
    input  wire dmon_s                  dmon_i,
    input  wire logic [ALLTRIG_NUM-1:0] bp_retire_i,
    output logic [XLEN-1:0]             csr_rdata_o,
    output logic [ALLTRIG_NUM-1:0]      ibrkpt_match_o,
    output logic                        ibrkpt_exc_req_o,
    output logic [MTRIG_NUM-1:0]        dbrkpt_match_o,
    output logic                        dbrkpt_exc_req_o,
    output logic                        dmode_req_o
);

    // CSR port to trigger state
    tdata1_u                        wr_data;
    logic [MTRIG_NUM-1:0]           mc_we;
    logic [MTRIG_NUM-1:0]           td2_we;
    logic                           ic_we;

    // Trigger state to comparators and read mux
    mc_state_s [MTRIG_NUM-1:0]      mc_state;
    logic [MTRIG_NUM-1:0][XLEN-1:0] tdata2;
    ic_state_s                      ic_state;
    logic                           ic_hit;

    tdu_csr_port #(
        .MTRIG_NUM (MTRIG_NUM)
    ) u_csr_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_req_i   (csr_req_i),
        .mc_state_i  (mc_state),
        .tdata2_i    (tdata2),
        .ic_state_i  (ic_state),
        .csr_rdata_o (csr_rdata_o),
        .wr_data_o   (wr_data),
        .mc_we_o     (mc_we),
        .td2_we_o    (td2_we),
        .ic_we_o     (ic_we)
    );

    tdu_mcontrol_bank #(
        .MTRIG_NUM (MTRIG_NUM)
    ) u_mcontrol_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_data_i   (wr_data),
        .mc_we_i     (mc_we),
        .td2_we_i    (td2_we),
        .bp_retire_i (bp_retire_i[MTRIG_NUM-1:0]),
        .mc_state_o  (mc_state),
        .tdata2_o    (tdata2)
    );

    tdu_icount u_icount (
        .clk        (clk),
        .rst_n      (rst_n),
        .tdu_dsbl_i (tdu_dsbl_i),
        .wr_data_i  (wr_data),
        .ic_we_i    (ic_we),
        .imon_i     (imon_i),
        .retire_i   (bp_retire_i[MTRIG_NUM]),
        .ic_state_o (ic_state),
        .ic_hit_o   (ic_hit)
    );

    tdu_match #(
        .MTRIG_NUM (MTRIG_NUM)
    ) u_match (
        .tdu_dsbl_i       (tdu_dsbl_i),
        .mc_state_i       (mc_state),
        .tdata2_i         (tdata2),
        .ic_state_i       (ic_state),
        .ic_hit_i         (ic_hit),
        .imon_i           (imon_i),
        .dmon_i           (dmon_i),
        .bp_retire_i      (bp_retire_i),
        .ibrkpt_match_o   (ibrkpt_match_o),
        .ibrkpt_exc_req_o (ibrkpt_exc_req_o),
        .dbrkpt_match_o   (dbrkpt_match_o),
        .dbrkpt_exc_req_o (dbrkpt_exc_req_o),
        .dmode_req_o      (dmode_req_o)
    );

endmodule

`default_nettype wire

/* verification/tdu_tb.sv */
//------------------------------------------------------------
// Table-driven testbench for the trigger debug unit
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tdu_tb import tdu_pkg::*; ;

    localparam int unsigned MTRIG_NUM     = 2;
    localparam int unsigned ALLTRIG_NUM   = MTRIG_NUM + 1;
    localparam int unsigned RESET_CYCLES  = 16;
    localparam int unsigned TIMEOUT_SLACK = 20;
    localparam logic [31:0] LFSR_SEED     = 32'd55557;
    localparam logic [31:0] LFSR_MASK     = 32'hA300_0000;

    // mcontrol field bits
    localparam logic [31:0] MC_TYPE  = 32'h2000_0000;
    localparam logic [31:0] MC_HIT   = 32'h0010_0000;
    localparam logic [31:0] MC_ACT1  = 32'h0000_1000;
    localparam logic [31:0] MC_M     = 32'h0000_0040;
    localparam logic [31:0] MC_EXEC  = 32'h0000_0004;
    localparam logic [31:0] MC_STORE = 32'h0000_0002;
    localparam logic [31:0] MC_LOAD  = 32'h0000_0001;

    // icount field bits, count starts at bit 10
    localparam logic [31:0] IC_TYPE   = 32'h3000_0000;
    localparam logic [31:0] IC_HIT    = 32'h0100_0000;
    localparam logic [31:0] IC_M      = 32'h0000_0200;
    localparam logic [31:0] IC_ACT1   = 32'h0000_0001;
    localparam logic [31:0] IC_COUNT1 = 32'h0000_0400;

    localparam logic [31:0] TINFO_MC = 32'h0000_0004;
    localparam logic [31:0] TINFO_IC = 32'h0000_0008;

    // One table row, stimulus then expected outputs
    typedef struct packed {
        csr_req_s               csr;
        imon_s                  imon;
        dmon_s                  dmon;
        logic                   dsbl;
        logic [ALLTRIG_NUM-1:0] retire;
        logic [XLEN-1:0]        exp_rdata;
        logic [ALLTRIG_NUM-1:0] exp_imatch;
        logic [MTRIG_NUM-1:0]   exp_dmatch;
        logic                   exp_dmode;
    } row_s;

    logic                   clk;
    logic                   rst_n;
    logic                   tdu_dsbl;
    csr_req_s               csr_req;
    imon_s                  imon;
    dmon_s                  dmon;
    logic [ALLTRIG_NUM-1:0] bp_retire;
    logic [XLEN-1:0]        csr_rdata;
    logic [ALLTRIG_NUM-1:0] ibrkpt_match;
    logic                   ibrkpt_exc_req;
    logic [MTRIG_NUM-1:0]   dbrkpt_match;
    logic                   dbrkpt_exc_req;
    logic                   dmode_req;

    row_s        tbl[$];
    row_s        cur;
    logic [31:0] lfsr_q = LFSR_SEED;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a_miss;
    int unsigned cycle_cnt   = 0;
    int unsigned cycle_limit = RESET_CYCLES + TIMEOUT_SLACK;

    tdu_top #(
        .MTRIG_NUM (MTRIG_NUM)
    ) u_tdu_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .tdu_dsbl_i       (tdu_dsbl),
        .csr_req_i        (csr_req),
        .imon_i           (imon),
        .dmon_i           (dmon),
        .bp_retire_i      (bp_retire),
        .csr_rdata_o      (csr_rdata),
        .ibrkpt_match_o   (ibrkpt_match),
        .ibrkpt_exc_req_o (ibrkpt_exc_req),
        .dbrkpt_match_o   (dbrkpt_match),
        .dbrkpt_exc_req_o (dbrkpt_exc_req),
        .dmode_req_o      (dmode_req)
    );

    always #5 clk = ~clk;

    // Run limit from the table length
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the table did not complete", cycle_limit);
            $display(">>> FAIL");
            $fatal(1, "run limit reached");
        end
    end

    //--------------------------------------------------------
    // Address source
    //--------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_MASK) : (s >> 1);
    endfunction

    // One step per bit, word aligned
    task automatic draw_addr(output logic [31:0] a);
        a = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            a      = {a[30:0], lfsr_q[0]};
        end
        a[1:0] = 2'b00;
    endtask

    //--------------------------------------------------------
    // Row builders
    //--------------------------------------------------------
    task automatic start_row();
        cur = '0;
    endtask

    task automatic set_csr(input csr_cmd_e cmd, input logic [CSR_OFFS_W-1:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp_rdata);
        cur.csr.req   = 1'b1;
        cur.csr.cmd   = cmd;
        cur.csr.addr  = addr;
        cur.csr.wdata = wdata;
        cur.exp_rdata = exp_rdata;
    endtask

    task automatic set_fetch(input logic retire, input logic [31:0] addr);
        cur.imon.vd   = 1'b1;
        cur.imon.req  = retire;
        cur.imon.addr = addr;
    endtask

    task automatic set_access(input logic load, input logic store, input logic [31:0] addr);
        cur.dmon.vd    = 1'b1;
        cur.dmon.load  = load;
        cur.dmon.store = store;
        cur.dmon.addr  = addr;
    endtask

    task automatic set_retire(input logic [ALLTRIG_NUM-1:0] retire, input logic exp_dmode);
        cur.retire    = retire;
        cur.exp_dmode = exp_dmode;
    endtask

    task automatic expect_match(input logic [ALLTRIG_NUM-1:0] imatch,
                                input logic [MTRIG_NUM-1:0] dmatch);
        cur.exp_imatch = imatch;
        cur.exp_dmatch = dmatch;
    endtask

    task automatic end_row();
        tbl.push_back(cur);
    endtask

    task automatic csr_row(input csr_cmd_e cmd, input logic [CSR_OFFS_W-1:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp_rdata);
        start_row();
        set_csr(cmd, addr, wdata, exp_rdata);
        end_row();
    endtask

    //--------------------------------------------------------
    // Stimulus table
    //--------------------------------------------------------
    task automatic build_table();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] v4;
        logic [31:0] w1;
        logic [31:0] c1;
        v1 = MC_TYPE | MC_HIT | MC_M | MC_EXEC | MC_STORE | MC_LOAD;
        v2 = MC_TYPE | MC_M | MC_STORE | MC_LOAD;
        v3 = v2 | MC_ACT1 | MC_EXEC;
        v4 = MC_TYPE | MC_M | MC_EXEC | MC_ACT1;
        w1 = MC_TYPE | MC_M | MC_LOAD | MC_STORE;
        c1 = IC_TYPE | IC_M | IC_COUNT1;
        // Reset values, idle row reads zero
        start_row();
        end_row();
        csr_row(CMD_NONE, OFFS_TSELECT, 0, 0);
        csr_row(CMD_NONE, OFFS_TDATA1, 0, MC_TYPE);
        csr_row(CMD_NONE, OFFS_TDATA2, 0, 0);
        csr_row(CMD_NONE, OFFS_TINFO, 0, TINFO_MC);
        // tdata2 still zero but m clear
        start_row();
        set_fetch(1'b0, 32'h0);
        set_access(1'b1, 1'b1, 32'h0);
        end_row();
        // Trigger 0, tdata2 write, set, clear
        csr_row(CMD_WRITE, OFFS_TDATA2, a0, 0);
        csr_row(CMD_NONE, OFFS_TDATA2, 0, a0);
        csr_row(CMD_SET, OFFS_TDATA2, 32'h3, a0);
        csr_row(CMD_NONE, OFFS_TDATA2, 0, a0 | 32'h3);
        csr_row(CMD_CLEAR, OFFS_TDATA2, 32'h3, a0 | 32'h3);
        csr_row(CMD_NONE, OFFS_TDATA2, 0, a0);
        // Unstored fields drop out
        csr_row(CMD_WRITE, OFFS_TDATA1, 32'hFFFF_FFFF, MC_TYPE);
        csr_row(CMD_NONE, OFFS_TDATA1, 0, v1);
        csr_row(CMD_CLEAR, OFFS_TDATA1, MC_HIT | MC_EXEC, v1);
        csr_row(CMD_NONE, OFFS_TDATA1, 0, v2);
        csr_row(CMD_SET, OFFS_TDATA1, MC_ACT1 | MC_EXEC, v2);
        csr_row(CMD_NONE, OFFS_TDATA1, 0, v3);
        // Set with zero mask writes nothing, so the retire lands
        start_row();
        set_csr(CMD_SET, OFFS_TDATA1, 0, v3);
        set_retire(3'b001, 1'b1);
        end_row();
        csr_row(CMD_NONE, OFFS_TDATA1, 0, v3 | MC_HIT);
        csr_row(CMD_CLEAR, OFFS_TDATA1, MC_HIT, v3 | MC_HIT);
        csr_row(CMD_NONE, OFFS_TDATA1, 0, v3);
        // tselect range
        csr_row(CMD_WRITE, OFFS_TSELECT, ALLTRIG_NUM, 0);
        csr_row(CMD_NONE, OFFS_TSELECT, 0, 0);
        csr_row(CMD_WRITE, OFFS_TSELECT, 32'h8000_0001, 0);
        csr_row(CMD_NONE, OFFS_TSELECT, 0, 0);
        csr_row(CMD_WRITE, OFFS_TSELECT, 1, 0);
        csr_row(CMD_NONE, OFFS_TSELECT, 0, 1);
        // Trigger 1 as load and store watchpoint
        csr_row(CMD_NONE, OFFS_TDATA1, 0, MC_TYPE);
        csr_row(CMD_WRITE, OFFS_TDATA2, a1, 0);
        csr_row(CMD_WRITE, OFFS_TDATA1, MC_M | MC_LOAD | MC_STORE, MC_TYPE);
        csr_row(CMD_NONE, OFFS_TDATA1, 0, w1);
        csr_row(CMD_NONE, OFFS_TDATA2, 0, a1);
        //----------------------------------------------------
        // Address matches
        //----------------------------------------------------
        start_row();
        set_fetch(1'b0, a0);
        expect_match(3'b001, 2'b00);
        end_row();
        start_row();
        set_access(1'b1, 1'b0, a1);
        expect_match(3'b000, 2'b10);
        end_row();
        start_row();
        set_access(1'b0, 1'b1, a0);
        expect_match(3'b000, 2'b01);
        end_row();
        start_row();
        set_fetch(1'b0, a0);
        set_access(1'b1, 1'b0, a1);
        expect_match(3'b001, 2'b10);
        end_row();
        start_row();
        set_fetch(1'b0, a_miss);
        set_access(1'b1, 1'b0, a_miss);
        end_row();
        start_row();
        cur.dsbl = 1'b1;
        set_fetch(1'b0, a0);
        set_access(1'b0, 1'b1, a1);
        end_row();
        // Trigger 1 has no execute
        start_row();
        set_fetch(1'b0, a1);
        end_row();
        //----------------------------------------------------
        // Hit bits and debug entry
        //----------------------------------------------------
        start_row();
        set_csr(CMD_NONE, OFFS_TDATA1, 0, w1);
        set_retire(3'b010, 1'b0);
        end_row();
        csr_row(CMD_NONE, OFFS_TDATA1, 0, w1 | MC_HIT);
        start_row();
        set_retire(3'b001, 1'b1);
        end_row();
        csr_row(CMD_WRITE, OFFS_TSELECT, 0, 1);
        csr_row(CMD_NONE, OFFS_TDATA1, 0, v3 | MC_HIT);
        // Write wins over the hit update
        start_row();
        set_csr(CMD_WRITE, OFFS_TDATA1, MC_M | MC_EXEC | MC_ACT1, v3 | MC_HIT);
        set_retire(3'b001, 1'b1);
        end_row();
        csr_row(CMD_NONE, OFFS_TDATA1, 0, v4);
        csr_row(CMD_CLEAR, OFFS_TDATA1, MC_M, v4);
        csr_row(CMD_NONE, OFFS_TDATA1, 0, v4 & ~MC_M);
        start_row();
        set_fetch(1'b0, a0);
        end_row();
        //----------------------------------------------------
        // Icount single step
        //----------------------------------------------------
        csr_row(CMD_WRITE, OFFS_TSELECT, 2, 0);
        csr_row(CMD_NONE, OFFS_TSELECT, 0, 2);
        csr_row(CMD_NONE, OFFS_TDATA1, 0, IC_TYPE);
        csr_row(CMD_NONE, OFFS_TINFO, 0, TINFO_IC);
        csr_row(CMD_NONE, OFFS_TDATA2, 0, 0);
        csr_row(CMD_WRITE, OFFS_TDATA1, IC_M | IC_COUNT1, IC_TYPE);
        // First retirement only clears the skip
        start_row();
        set_csr(CMD_NONE, OFFS_TDATA1, 0, c1);
        set_fetch(1'b1, a_miss);
        end_row();
        start_row();
        set_fetch(1'b0, a_miss);
        expect_match(3'b100, 2'b00);
        end_row();
        start_row();
        set_fetch(1'b1, a_miss);
        set_retire(3'b100, 1'b0);
        expect_match(3'b100, 2'b00);
        end_row();
        // Count now zero
        start_row();
        set_csr(CMD_NONE, OFFS_TDATA1, 0, IC_TYPE | IC_HIT | IC_M);
        set_fetch(1'b1, a_miss);
        end_row();
        csr_row(CMD_SET, OFFS_TDATA1, IC_ACT1, IC_TYPE | IC_HIT | IC_M);
        start_row();
        set_csr(CMD_NONE, OFFS_TDATA1, 0, IC_TYPE | IC_HIT | IC_M | IC_ACT1);
        set_retire(3'b100, 1'b1);
        end_row();
        start_row();
        end_row();
    endtask

    //--------------------------------------------------------
    // Drive and compare
    //--------------------------------------------------------
    task automatic drive_row(input row_s r);
        csr_req   = r.csr;
        imon      = r.imon;
        dmon      = r.dmon;
        tdu_dsbl  = r.dsbl;
        bp_retire = r.retire;
    endtask

    task automatic check_value(input string name, input int idx,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: row %0d, %s is %h, expected %h",
                     $time, idx, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_row(input row_s r, input int idx);
        check_value("csr_rdata_o", idx, csr_rdata, r.exp_rdata);
        check_value("ibrkpt_match_o", idx, 32'(ibrkpt_match), 32'(r.exp_imatch));
        check_value("ibrkpt_exc_req_o", idx, 32'(ibrkpt_exc_req), 32'(|r.exp_imatch));
        check_value("dbrkpt_match_o", idx, 32'(dbrkpt_match), 32'(r.exp_dmatch));
        check_value("dbrkpt_exc_req_o", idx, 32'(dbrkpt_exc_req), 32'(|r.exp_dmatch));
        check_value("dmode_req_o", idx, 32'(dmode_req), 32'(r.exp_dmode));
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        tdu_dsbl  = 1'b0;
        csr_req   = '0;
        imon      = '0;
        dmon      = '0;
        bp_retire = '0;
        draw_addr(a0);
        draw_addr(a1);
        draw_addr(a_miss);
        assert (a0 != a1 && a0 != a_miss && a1 != a_miss && a0 != 0 && a1 != 0) else begin
            $display("LFSR produced colliding or zero trigger addresses");
            $display(">>> FAIL");
            $fatal(1, "bad address set");
        end
        build_table();
        cycle_limit = tbl.size() + RESET_CYCLES + TIMEOUT_SLACK;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // One row per cycle, checked late in the cycle
        for (int i = 0; i < tbl.size(); i++) begin
            drive_row(tbl[i]);
            #7;
            check_row(tbl[i], i);
            @(posedge clk);
            #1;
        end
        drive_row('0);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tdu_top.f */
hw/tdu_pkg.sv
hw/tdu_csr_port.sv
hw/tdu_mcontrol_bank.sv
hw/tdu_icount.sv
hw/tdu_match.sv
hw/tdu_top.sv
verification/tdu_tb.sv

/* Makefile */
# Verilator flow for the trigger debug unit

VERILATOR  ?= verilator
TOP        := tdu_tb
FILELIST   := tdu_top.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
SIM_LOG    := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	grep -qx '>>> PASS' $(SIM_LOG)

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)
